// ==== common/opn_reg_pkg.sv ====
`default_nettype none

// Register map and control byte layout of the CPU interface
package opn_reg_pkg;

    // Register number held in the address latch
    typedef logic [7:0] reg_addr_t;

    // Timer registers
    localparam reg_addr_t REG_TA_HI     = 8'h24; // Timer A bits 9:2
    localparam reg_addr_t REG_TA_LO     = 8'h25; // Timer A bits 1:0
    localparam reg_addr_t REG_TB        = 8'h26; // Timer B value
    localparam reg_addr_t REG_TIMER_CTL = 8'h27; // Load, enable and reset bits

    // Bit positions inside a REG_TIMER_CTL write
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_IRQ_A  = 2;
    localparam int CTL_IRQ_B  = 3;
    localparam int CTL_CLR_A  = 4; // Write 1 to clear flag A
    localparam int CTL_CLR_B  = 5; // Write 1 to clear flag B

    // Control of one timer as seen by the counter.
    // load and irq_en are levels kept from the last control write,
    // clr_flag lasts a single cycle
    typedef struct packed {
        logic load;     // Run the counter
        logic irq_en;   // Allow overflow to set the flag
        logic clr_flag; // Clear pulse
    } timer_ctrl_t;

endpackage : opn_reg_pkg

`default_nettype wire

// ==== common/opn_timer_pkg.sv ====
`default_nettype none

// Timer widths, prescale and status byte layout
package opn_timer_pkg;

    typedef logic [9:0] ta_value_t; // Timer A reload value
    typedef logic [7:0] tb_value_t; // Timer B reload value

    // Ticks per counter step
    localparam int TA_PRESCALE = 1;
    localparam int TB_PRESCALE = 16;

    // Busy window after each data write, in clock cycles
    localparam int BUSY_CYCLES = 32;

    // Wide enough to hold BUSY_CYCLES itself
    typedef logic [$clog2(BUSY_CYCLES+1)-1:0] busy_cnt_t;

    // Status byte bit positions
    localparam int STAT_BUSY   = 7;
    localparam int STAT_FLAG_B = 1;
    localparam int STAT_FLAG_A = 0;

    typedef logic [7:0] status_t;

endpackage : opn_timer_pkg

`default_nettype wire

// ==== timers/timer_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

// Prescaled up-counter that reloads on overflow and raises a sticky flag
module timer_counter
    import opn_reg_pkg::*;
#(
    parameter int WIDTH    = 10,
    parameter int PRESCALE = 1
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             tick,
    input  logic [WIDTH-1:0] value,
    input  timer_ctrl_t      ctrl,
    output logic             flag
);

    logic [WIDTH-1:0] cnt;
    logic             step;     // One counter advance
    logic             overflow;

    generate
        if (PRESCALE > 1) begin : gen_prescale
            localparam int PW = $clog2(PRESCALE);

            logic [PW-1:0] pre;

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    pre <= '0;
                end else if (!ctrl.load) begin
                    pre <= '0;  // Restart the division on every load
                end else if (tick) begin
                    if (pre == PW'(PRESCALE - 1)) begin
                        pre <= '0;
                    end else begin
                        pre <= pre + 1'b1;
                    end
                end
            end

            assign step = tick && (pre == PW'(PRESCALE - 1));
        end else begin : gen_no_prescale
            assign step = tick;
        end
    endgenerate

    assign overflow = step && (&cnt);

    // Count register, parked on the reload value while stopped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (!ctrl.load || overflow) begin
            cnt <= value;
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

    // Flag holds until cleared, clear wins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag <= 1'b0;
        end else if (ctrl.clr_flag) begin
            flag <= 1'b0;
        end else if (ctrl.load && overflow && ctrl.irq_en) begin
            flag <= 1'b1;
        end
    end

endmodule : timer_counter

`default_nettype wire

// ==== hdl/opn_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

// CPU write decode, address latch and timer registers
module opn_regs
    import opn_reg_pkg::*;
    import opn_timer_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [7:0]  din,
    input  logic [1:0]  addr,
    input  logic        cs_n,
    input  logic        wr_n,
    output ta_value_t   ta_value,
    output tb_value_t   tb_value,
    output timer_ctrl_t ctrl_a,
    output timer_ctrl_t ctrl_b,
    output logic        data_wr
);

    logic      write;
    logic      addr_we;
    logic      data_we;
    logic      ctl_we;
    reg_addr_t reg_addr;   // Selected register
    logic [7:0] ta_hi;
    logic [1:0] ta_lo;

    assign write   = !cs_n && !wr_n;
    assign addr_we = write && !addr[0]; // A0 low selects the address port
    assign data_we = write &&  addr[0];
    assign ctl_we  = data_we && (reg_addr == REG_TIMER_CTL);

    assign ta_value = {ta_hi, ta_lo};

    // Address latch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_addr <= '0;
        end else if (addr_we) begin
            reg_addr <= din;
        end
    end

    // Timer value registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ta_hi    <= '0;
            ta_lo    <= '0;
            tb_value <= '0;
        end else if (data_we) begin
            case (reg_addr)
                REG_TA_HI: ta_hi    <= din;
                REG_TA_LO: ta_lo    <= din[1:0];
                REG_TB:    tb_value <= din;
                default: ;  // Other numbers have no effect here
            endcase
        end
    end

    // Control levels follow the last control write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_a.load   <= 1'b0;
            ctrl_a.irq_en <= 1'b0;
            ctrl_b.load   <= 1'b0;
            ctrl_b.irq_en <= 1'b0;
        end else if (ctl_we) begin
            ctrl_a.load   <= din[CTL_LOAD_A];
            ctrl_a.irq_en <= din[CTL_IRQ_A];
            ctrl_b.load   <= din[CTL_LOAD_B];
            ctrl_b.irq_en <= din[CTL_IRQ_B];
        end
    end

    // Single cycle strobes in the cycle after the write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_a.clr_flag <= 1'b0;
            ctrl_b.clr_flag <= 1'b0;
            data_wr         <= 1'b0;
        end else begin
            ctrl_a.clr_flag <= ctl_we && din[CTL_CLR_A];
            ctrl_b.clr_flag <= ctl_we && din[CTL_CLR_B];
            data_wr         <= data_we; // Any data write starts busy
        end
    end

endmodule : opn_regs

`default_nettype wire

// ==== hdl/status_port.sv ====
`timescale 1ns/100ps
`default_nettype none

// Busy window, status byte and interrupt line
module status_port
    import opn_timer_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    data_wr,
    input  logic    flag_a,
    input  logic    flag_b,
    output status_t dout,
    output logic    irq_n
);

    busy_cnt_t busy_cnt;
    logic      busy;

    // Reloaded by each data write, so a late write extends the window
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= busy_cnt_t'(BUSY_CYCLES);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);

    // Same byte for every read address
    always_comb begin
        dout              = '0;
        dout[STAT_BUSY]   = busy;
        dout[STAT_FLAG_B] = flag_b;
        dout[STAT_FLAG_A] = flag_a;
    end

    assign irq_n = !(flag_a || flag_b); // Low while any flag is up

endmodule : status_port

`default_nettype wire

// ==== hdl/opn_timer_top.sv ====
`timescale 1ns/100ps
`default_nettype none

// Control core of the sound chip: bus registers, two timers, status
module opn_timer_top
    import opn_reg_pkg::*;
    import opn_timer_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       tick,    // Timer base enable
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output status_t    dout,
    output logic       irq_n
);

    ta_value_t   ta_value;
    tb_value_t   tb_value;
    timer_ctrl_t ctrl_a;
    timer_ctrl_t ctrl_b;
    logic        data_wr;
    logic        flag_a;
    logic        flag_b;

    opn_regs u_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .din      (din),
        .addr     (addr),
        .cs_n     (cs_n),
        .wr_n     (wr_n),
        .ta_value (ta_value),
        .tb_value (tb_value),
        .ctrl_a   (ctrl_a),
        .ctrl_b   (ctrl_b),
        .data_wr  (data_wr)
    );

    // Timer A steps on every tick
    timer_counter #(
        .WIDTH    ($bits(ta_value_t)),
        .PRESCALE (TA_PRESCALE)
    ) u_timer_a (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick),
        .value  (ta_value),
        .ctrl   (ctrl_a),
        .flag   (flag_a)
    );

    // Timer B is sixteen times slower
    timer_counter #(
        .WIDTH    ($bits(tb_value_t)),
        .PRESCALE (TB_PRESCALE)
    ) u_timer_b (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick),
        .value  (tb_value),
        .ctrl   (ctrl_b),
        .flag   (flag_b)
    );

    status_port u_status (
        .clk     (clk),
        .arst_n  (arst_n),
        .data_wr (data_wr),
        .flag_a  (flag_a),
        .flag_b  (flag_b),
        .dout    (dout),
        .irq_n   (irq_n)
    );

endmodule : opn_timer_top

`default_nettype wire

// ==== tests/opn_timer_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

// Invariants of the timer core, bound into the top level
module opn_timer_properties
    import opn_timer_pkg::*;
(
    input logic    clk,
    input logic    arst_n,
    input logic    data_wr,
    input logic    flag_a,
    input logic    flag_b,
    input logic    clr_a,
    input logic    clr_b,
    input status_t dout,
    input logic    irq_n
);

    int fail_count = 0; // Failed assertions so far

    irq_follows_flags: assert property (
        @(posedge clk) disable iff (!arst_n) irq_n == !(flag_a || flag_b)
    ) else begin
        fail_count++;
        $error("irq_n does not match the timer flags");
    end

    // Busy window opens one edge after the data strobe
    busy_after_write: assert property (
        @(posedge clk) disable iff (!arst_n) data_wr |=> dout[STAT_BUSY]
    ) else begin
        fail_count++;
        $error("busy not set after a data write");
    end

    clear_a_wins: assert property (
        @(posedge clk) disable iff (!arst_n) clr_a |=> !flag_a
    ) else begin
        fail_count++;
        $error("flag A still set after its clear pulse");
    end

    clear_b_wins: assert property (
        @(posedge clk) disable iff (!arst_n) clr_b |=> !flag_b
    ) else begin
        fail_count++;
        $error("flag B still set after its clear pulse");
    end

endmodule : opn_timer_properties

bind opn_timer_top opn_timer_properties u_props (
    .clk     (clk),
    .arst_n  (arst_n),
    .data_wr (data_wr),
    .flag_a  (flag_a),
    .flag_b  (flag_b),
    .clr_a   (ctrl_a.clr_flag),
    .clr_b   (ctrl_b.clr_flag),
    .dout    (dout),
    .irq_n   (irq_n)
);

`default_nettype wire

// ==== tests/tb_opn_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

// Directed tests of the timer control core
module tb_opn_timer
    import opn_reg_pkg::*;
    import opn_timer_pkg::*;
();

    localparam int MAX_CYCLES = 20000; // Far above the length of all tests

    // Status byte layout
    localparam int FLAG_B_BIT = 1;
    localparam int FLAG_A_BIT = 0;

    localparam logic [7:0] TA_HI_VAL = 8'hFE;
    localparam int TA_PERIOD = 1024 - {TA_HI_VAL, 2'b00}; // 8 ticks
    localparam logic [7:0] TB_VAL = 8'hFC;
    localparam int TB_PERIOD = (256 - TB_VAL) * 16;        // 64 ticks

    logic       clk;
    logic       arst_n;
    logic       tick;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    status_t    dout;
    logic       irq_n;

    int    tick_every = 1;
    int    tick_phase = 0;
    int    cycles = 0;
    int    test_errors;
    int    tests_ok;
    int    tests_bad;
    string test_name;

    opn_timer_top DUT (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick),
        .din    (din),
        .addr   (addr),
        .cs_n   (cs_n),
        .wr_n   (wr_n),
        .dout   (dout),
        .irq_n  (irq_n)
    );

    always #5 clk = ~clk;

    // Tick enable, one in every tick_every cycles
    always @(negedge clk) begin
        if (tick_phase >= tick_every - 1) begin
            tick_phase <= 0;
            tick       <= 1'b1;
        end else begin
            tick_phase <= tick_phase + 1;
            tick       <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Address cycle then data cycle, called on a falling edge
    task automatic write_reg(input reg_addr_t num, input logic [7:0] data);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'd0;
        din  = num;
        @(negedge clk);
        addr = 2'd1;
        din  = data;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
        addr = 2'd0;
        din  = 8'h00;
    endtask

    task automatic check_value(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic wait_flag(input int pos, input int limit, input string what);
        int waited;
        waited = 0;
        while (waited < limit && dout[pos] !== 1'b1) begin
            @(negedge clk);
            waited++;
        end
        if (dout[pos] !== 1'b1) begin
            $display("%s: %s did not set within %0d cycles", test_name, what, limit);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", test_name, test_errors);
            tests_bad++;
        end
    endtask

    task automatic reset_state();
        start_test("reset_state");
        check_value("status", 8'h00, dout);
        check_value("irq_n", 8'd1, irq_n);
        finish_test();
    endtask

    task automatic busy_window();
        start_test("busy_window");
        write_reg(REG_TB, 8'h00);
        idle(1);
        check_value("busy start", 8'h80, dout);
        idle(BUSY_CYCLES - 2);
        check_value("busy late", 8'h80, dout);
        idle(2);
        check_value("busy over", 8'h00, dout);
        // Second write halfway through restarts the window
        write_reg(REG_TB, 8'h00);
        idle(BUSY_CYCLES / 2);
        write_reg(REG_TB, 8'h00);
        idle(BUSY_CYCLES - 2);
        check_value("busy extended", 8'h80, dout);
        idle(3);
        check_value("busy end", 8'h00, dout);
        finish_test();
    endtask

    task automatic timer_a_overflow();
        start_test("timer_a_overflow");
        write_reg(REG_TA_HI, TA_HI_VAL);
        write_reg(REG_TA_LO, 8'h00);
        write_reg(REG_TIMER_CTL, 8'h05); // Load A, irq A
        idle(TA_PERIOD - 2);
        check_value("flag A early", 8'd0, dout[FLAG_A_BIT]);
        wait_flag(FLAG_A_BIT, 5, "flag A");
        check_value("irq_n", 8'd0, irq_n);
        check_value("flag B", 8'd0, dout[FLAG_B_BIT]);
        write_reg(REG_TIMER_CTL, 8'h30); // Stop and clear both
        idle(1);
        check_value("irq_n after stop", 8'd1, irq_n);
        finish_test();
    endtask

    task automatic timer_b_prescale();
        start_test("timer_b_prescale");
        tick_every = 3;
        write_reg(REG_TB, TB_VAL);
        write_reg(REG_TIMER_CTL, 8'h0A); // Load B, irq B
        idle(TB_PERIOD * 3 - 5);
        check_value("flag B early", 8'd0, dout[FLAG_B_BIT]);
        wait_flag(FLAG_B_BIT, 13, "flag B");
        check_value("irq_n", 8'd0, irq_n);
        check_value("flag A", 8'd0, dout[FLAG_A_BIT]);
        write_reg(REG_TIMER_CTL, 8'h20);
        tick_every = 1;
        idle(1);
        check_value("irq_n after stop", 8'd1, irq_n);
        finish_test();
    endtask

    task automatic flag_enable_clear();
        start_test("flag_enable_clear");
        write_reg(REG_TIMER_CTL, 8'h01); // Running, flag masked
        idle(4 * TA_PERIOD);
        check_value("masked flag A", 8'd0, dout[FLAG_A_BIT]);
        check_value("masked irq_n", 8'd1, irq_n);
        write_reg(REG_TIMER_CTL, 8'h05);
        wait_flag(FLAG_A_BIT, TA_PERIOD + 3, "flag A");
        write_reg(REG_TIMER_CTL, 8'h10);
        idle(1);
        check_value("cleared flag A", 8'd0, dout[FLAG_A_BIT]);
        check_value("irq_n", 8'd1, irq_n);
        finish_test();
    endtask

    task automatic periodic_reload();
        start_test("periodic_reload");
        write_reg(REG_TIMER_CTL, 8'h05);
        wait_flag(FLAG_A_BIT, TA_PERIOD + 3, "first flag A");
        write_reg(REG_TIMER_CTL, 8'h15); // Clear but keep counting
        idle(1);
        check_value("cleared flag A", 8'd0, dout[FLAG_A_BIT]);
        wait_flag(FLAG_A_BIT, TA_PERIOD + 1, "reloaded flag A");
        write_reg(REG_TIMER_CTL, 8'h10);
        finish_test();
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        tick      = 1'b0;
        din       = 8'h00;
        addr      = 2'd0;
        cs_n      = 1'b1;
        wr_n      = 1'b1;
        tests_ok  = 0;
        tests_bad = 0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        reset_state();
        busy_window();
        timer_a_overflow();
        timer_b_prescale();
        flag_enable_clear();
        periodic_reload();

        $display("tests ok %0d, bad %0d, assertion failures %0d",
                 tests_ok, tests_bad, DUT.u_props.fail_count);
        if (tests_bad == 0 && DUT.u_props.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_opn_timer

`default_nettype wire

// ==== tb.f ====
common/opn_reg_pkg.sv
common/opn_timer_pkg.sv
timers/timer_counter.sv
hdl/opn_regs.sv
hdl/status_port.sv
hdl/opn_timer_top.sv
tests/opn_timer_properties.sv
tests/tb_opn_timer.sv
